// File: tb.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/stage_latch.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/mem_wb_unit.sv
hw/processor.sv
bench/processor_properties.sv
bench/tb_top.sv

// File: bench/tb_top.sv
`timescale 1ns/1ns
`include "proc_params.svh"

module tb_top import isa_pkg::*; ();

    localparam int PROG_LEN    = 48;
    localparam int NUM_PROGS   = 4;
    localparam int CYCLE_LIMIT = PROG_LEN * 3 + 40;

    logic               clock;
    logic               rst;
    logic [`XLEN-1:0]   q_imem;
    logic [`XLEN-1:0]   q_dmem;
    logic [`XLEN-1:0]   data_readRegA;
    logic [`XLEN-1:0]   data_readRegB;
    logic [`IMEM_W-1:0] address_imem;
    logic [`XLEN-1:0]   address_dmem;
    logic [`XLEN-1:0]   data;
    logic               wren;
    logic               ctrl_writeEnable;
    logic [`REG_W-1:0]  ctrl_writeReg;
    logic [`REG_W-1:0]  ctrl_readRegA;
    logic [`REG_W-1:0]  ctrl_readRegB;
    logic [`XLEN-1:0]   data_writeReg;

    logic [`XLEN-1:0] imem [0:63];
    logic [`XLEN-1:0] dmem [0:255];
    logic [`XLEN-1:0] mem_model [0:255];
    logic [`XLEN-1:0] rf [0:31];
    // Entries are {rd, value} and {address, data}
    logic [63:0]      exp_writes [$];
    logic [63:0]      exp_stores [$];
    integer           seed;
    int               cyc;
    int               rst_cycles;
    int               val_errs;
    int               other_errs;

    processor DUT (
        .clock            (clock),
        .rst              (rst),
        .q_imem           (q_imem),
        .q_dmem           (q_dmem),
        .data_readRegA    (data_readRegA),
        .data_readRegB    (data_readRegB),
        .address_imem     (address_imem),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg),
        .ctrl_readRegA    (ctrl_readRegA),
        .ctrl_readRegB    (ctrl_readRegB),
        .data_writeReg    (data_writeReg)
    );

    bind processor processor_properties u_props (
        .clock            (clock),
        .rst              (rst),
        .stall            (stall),
        .address_imem     (address_imem),
        .wren             (wren),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg)
    );

    always #20 clock = ~clock;

    assign q_imem = imem[address_imem[5:0]];
    assign q_dmem = dmem[address_dmem[7:0]];

    // Write-through register file, r0 reads as zero
    assign data_readRegA = (ctrl_readRegA == '0) ? '0 :
        (ctrl_writeEnable && ctrl_writeReg == ctrl_readRegA) ? data_writeReg : rf[ctrl_readRegA];
    assign data_readRegB = (ctrl_readRegB == '0) ? '0 :
        (ctrl_writeEnable && ctrl_writeReg == ctrl_readRegB) ? data_writeReg : rf[ctrl_readRegB];

    always @(posedge clock) begin
        if (wren) begin
            dmem[address_dmem[7:0]] <= data;
        end
        if (ctrl_writeEnable && ctrl_writeReg != '0) begin
            rf[ctrl_writeReg] <= data_writeReg;
        end
    end

    task automatic build_program;
        int         kind;
        int         offs;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] aop;
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            kind = $unsigned($random(seed)) % 20;
            rd   = $unsigned($random(seed)) % 6;
            rs   = $unsigned($random(seed)) % 6;
            rt   = $unsigned($random(seed)) % 6;
            aop  = $unsigned($random(seed)) % 6;
            // Forward only, never past the final jump
            offs = $unsigned($random(seed)) % 4;
            if (i + 1 + offs > PROG_LEN - 1) begin
                offs = PROG_LEN - 2 - i;
            end
            if (kind < 8) begin
                imem[i] = {OP_R, rd, rs, rt, 5'($random(seed)), aop, 2'b00};
            end else if (kind < 11) begin
                imem[i] = {OP_ADDI, rd, rs, 17'($random(seed))};
            end else if (kind < 13) begin
                imem[i] = {OP_LW, rd, rs, 17'($unsigned($random(seed)) % 32)};
            end else if (kind < 15) begin
                imem[i] = {OP_SW, rd, rs, 17'($unsigned($random(seed)) % 32)};
            end else if (kind < 17) begin
                imem[i] = {OP_BNE, rd, rs, 17'(offs)};
            end else if (kind < 19) begin
                imem[i] = {OP_BLT, rd, rs, 17'(offs)};
            end else begin
                imem[i] = {OP_J, 27'(i + 1 + offs)};
            end
        end
        imem[PROG_LEN-1] = {OP_J, 27'(PROG_LEN - 1)};
    endtask

    task automatic fill_data_memory;
        for (int i = 0; i < 256; i++) begin
            dmem[i]      = $random(seed);
            mem_model[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
        end
    endtask

    // In-order ISA model
    task automatic run_reference;
        logic [`XLEN-1:0] r [0:31];
        logic [`XLEN-1:0] w;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] res;
        logic [`XLEN-1:0] addr;
        logic [4:0]       rd;
        logic             wr;
        logic             done;
        int               pc;
        int               next_pc;
        int               steps;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        pc    = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 400) begin
            w       = imem[pc];
            rd      = w[26:22];
            a       = r[w[21:17]];
            b       = r[rd];
            imm     = {{15{w[16]}}, w[16:0]};
            wr      = 1'b0;
            next_pc = pc + 1;
            steps++;
            case (w[31:27])
                OP_R: begin
                    wr = 1'b1;
                    case (w[6:2])
                        ALU_ADD: res = a + r[w[16:12]];
                        ALU_SUB: res = a - r[w[16:12]];
                        ALU_AND: res = a & r[w[16:12]];
                        ALU_OR:  res = a | r[w[16:12]];
                        ALU_SLL: res = a << w[11:7];
                        ALU_SRA: res = $signed(a) >>> w[11:7];
                        default: res = '0;
                    endcase
                end
                OP_ADDI: begin
                    wr  = 1'b1;
                    res = a + imm;
                end
                OP_LW: begin
                    wr   = 1'b1;
                    addr = a + imm;
                    res  = mem_model[addr[7:0]];
                end
                OP_SW: begin
                    addr = a + imm;
                    mem_model[addr[7:0]] = b;
                    exp_stores.push_back({addr, b});
                end
                OP_BNE: begin
                    if (b != a) begin
                        next_pc = pc + 1 + imm;
                    end
                end
                OP_BLT: begin
                    if ($signed(b) < $signed(a)) begin
                        next_pc = pc + 1 + imm;
                    end
                end
                OP_J: begin
                    next_pc = w[26:0];
                    done    = (next_pc == pc);
                end
                default: ;
            endcase
            if (wr && rd != '0) begin
                r[rd] = res;
                exp_writes.push_back({27'b0, rd, res});
            end
            pc = next_pc;
        end
    endtask

    task automatic check_store;
        logic [63:0] entry;
        if (exp_stores.size() == 0) begin
            $display("unexpected store to address %h", address_dmem);
            other_errs++;
        end else begin
            entry = exp_stores.pop_front();
            if (address_dmem !== entry[63:32]) begin
                $display("mismatch address_dmem: got %h expected %h", address_dmem, entry[63:32]);
                val_errs++;
            end
            if (data !== entry[31:0]) begin
                $display("mismatch data: got %h expected %h", data, entry[31:0]);
                val_errs++;
            end
        end
    endtask

    task automatic check_write;
        logic [63:0] entry;
        if (ctrl_writeReg == '0) begin
            $display("register write to r0 was not suppressed");
            other_errs++;
        end else if (exp_writes.size() == 0) begin
            $display("unexpected register write to r%0d", ctrl_writeReg);
            other_errs++;
        end else begin
            entry = exp_writes.pop_front();
            if (ctrl_writeReg !== entry[36:32]) begin
                $display("mismatch ctrl_writeReg: got %h expected %h",
                         ctrl_writeReg, entry[36:32]);
                val_errs++;
            end
            if (data_writeReg !== entry[31:0]) begin
                $display("mismatch data_writeReg: got %h expected %h",
                         data_writeReg, entry[31:0]);
                val_errs++;
            end
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clock) begin
        if (rst) begin
            if (rst_cycles > 0 && (wren || ctrl_writeEnable)) begin
                $display("write enable high during reset at %0t", $time);
                other_errs++;
            end
            rst_cycles++;
            cyc = 0;
        end else begin
            rst_cycles = 0;
            if (cyc == 0 && address_imem !== '0) begin
                $display("mismatch address_imem: got %h expected %h", address_imem, 12'h0);
                val_errs++;
            end
            if ((wren && cyc < 3) || (ctrl_writeEnable && cyc < 4)) begin
                $display("write seen before the first instruction could reach that stage");
                other_errs++;
            end
            if (wren) begin
                check_store();
            end
            if (ctrl_writeEnable) begin
                check_write();
            end
            cyc++;
        end
    end

    initial begin
        seed       = 32'hc7ff6566;
        clock      = 1'b0;
        rst        = 1'b1;
        cyc        = 0;
        rst_cycles = 0;
        val_errs   = 0;
        other_errs = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        fill_data_memory();
        for (int p = 0; p < NUM_PROGS; p++) begin
            @(posedge clock);
            #1 rst = 1'b1;
            // Latches hold bubbles before the memories change
            repeat (2) @(posedge clock);
            build_program();
            fill_data_memory();
            run_reference();
            repeat (3) @(posedge clock);
            #1 rst = 1'b0;
            while ((exp_writes.size() != 0 || exp_stores.size() != 0) && cyc < CYCLE_LIMIT) begin
                @(posedge clock);
            end
            if (exp_writes.size() != 0 || exp_stores.size() != 0) begin
                $display("timeout in program %0d after %0d cycles, %0d writes and %0d stores missing",
                         p, cyc, exp_writes.size(), exp_stores.size());
                other_errs++;
                exp_writes.delete();
                exp_stores.delete();
            end
            // Extra writes from flushed instructions would show up here
            repeat (10) @(posedge clock);
        end
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 val_errs, other_errs, DUT.u_props.fail_count);
        if (val_errs == 0 && other_errs == 0 && DUT.u_props.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: bench/processor_properties.sv
`timescale 1ns/1ns
`include "proc_params.svh"

module processor_properties (
    input logic               clock,
    input logic               rst,
    input logic               stall,
    input logic [`IMEM_W-1:0] address_imem,
    input logic               wren,
    input logic               ctrl_writeEnable,
    input logic [`REG_W-1:0]  ctrl_writeReg
);

    int fail_count = 0;

    // r0 writes never leave the core
    write_not_r0: assert property (@(posedge clock) disable iff (rst)
        ctrl_writeEnable |-> ctrl_writeReg != '0)
        else begin
            $error("register write enabled with r0 as destination");
            fail_count++;
        end

    // PC frozen by a load-use stall
    stall_holds_pc: assert property (@(posedge clock) disable iff (rst)
        stall |=> $stable(address_imem))
        else begin
            $error("address_imem moved during a stall");
            fail_count++;
        end

    reset_clears_writes: assert property (@(posedge clock)
        rst |=> (!wren && !ctrl_writeEnable))
        else begin
            $error("write enable high in the cycle after reset");
            fail_count++;
        end

endmodule

// File: hw/processor.sv
`timescale 1ns/1ns
`include "proc_params.svh"

module processor import pipe_pkg::*; (
    input  logic               clock,
    input  logic               rst,
    input  logic [`XLEN-1:0]   q_imem,
    input  logic [`XLEN-1:0]   q_dmem,
    input  logic [`XLEN-1:0]   data_readRegA,
    input  logic [`XLEN-1:0]   data_readRegB,
    output logic [`IMEM_W-1:0] address_imem,
    output logic [`XLEN-1:0]   address_dmem,
    output logic [`XLEN-1:0]   data,
    output logic               wren,
    output logic               ctrl_writeEnable,
    output logic [`REG_W-1:0]  ctrl_writeReg,
    output logic [`REG_W-1:0]  ctrl_readRegA,
    output logic [`REG_W-1:0]  ctrl_readRegB,
    output logic [`XLEN-1:0]   data_writeReg
);

    fd_t              fd_d;
    fd_t              fd_q;
    dx_t              dx_d;
    dx_t              dx_q;
    xm_t              xm_d;
    xm_t              xm_q;
    mw_t              mw_d;
    mw_t              mw_q;
    logic             stall;
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;
    logic             fd_en;
    logic             dx_flush;
    logic [`XLEN-1:0] wb_data;

    // Stall holds FD and drops a bubble into DX
    assign fd_en    = !stall;
    assign dx_flush = redirect || stall;

    fetch_unit u_fetch (
        .clock        (clock),
        .rst          (rst),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .q_imem       (q_imem),
        .address_imem (address_imem),
        .fd           (fd_d)
    );

    stage_latch #(.payload_t(fd_t)) u_fd_latch (
        .clock (clock),
        .rst   (rst),
        .en    (fd_en),
        .flush (redirect),
        .d     (fd_d),
        .q     (fd_q)
    );

    decode_unit u_decode (
        .fd            (fd_q),
        .dx_q          (dx_q),
        .data_readRegA (data_readRegA),
        .data_readRegB (data_readRegB),
        .ctrl_readRegA (ctrl_readRegA),
        .ctrl_readRegB (ctrl_readRegB),
        .dx            (dx_d),
        .stall         (stall)
    );

    stage_latch #(.payload_t(dx_t)) u_dx_latch (
        .clock (clock),
        .rst   (rst),
        .en    (1'b1),
        .flush (dx_flush),
        .d     (dx_d),
        .q     (dx_q)
    );

    execute_unit u_execute (
        .dx          (dx_q),
        .xm_q        (xm_q),
        .mw_q        (mw_q),
        .wb_data     (wb_data),
        .xm          (xm_d),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    stage_latch #(.payload_t(xm_t)) u_xm_latch (
        .clock (clock),
        .rst   (rst),
        .en    (1'b1),
        .flush (1'b0),
        .d     (xm_d),
        .q     (xm_q)
    );

    mem_wb_unit u_mem_wb (
        .xm_q             (xm_q),
        .mw_q             (mw_q),
        .q_dmem           (q_dmem),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .mw               (mw_d),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg),
        .data_writeReg    (data_writeReg),
        .wb_data          (wb_data)
    );

    stage_latch #(.payload_t(mw_t)) u_mw_latch (
        .clock (clock),
        .rst   (rst),
        .en    (1'b1),
        .flush (1'b0),
        .d     (mw_d),
        .q     (mw_q)
    );

endmodule

// File: hw/mem_wb_unit.sv
`timescale 1ns/1ns
`include "proc_params.svh"

module mem_wb_unit import isa_pkg::*, pipe_pkg::*; (
    input  xm_t               xm_q,
    input  mw_t               mw_q,
    input  logic [`XLEN-1:0]  q_dmem,
    output logic [`XLEN-1:0]  address_dmem,
    output logic [`XLEN-1:0]  data,
    output logic              wren,
    output mw_t               mw,
    output logic              ctrl_writeEnable,
    output logic [`REG_W-1:0] ctrl_writeReg,
    output logic [`XLEN-1:0]  data_writeReg,
    output logic [`XLEN-1:0]  wb_data
);

    opcode_t           mw_op;
    logic [`REG_W-1:0] mw_rd;
    logic              mw_writes;
    logic [`XLEN-1:0]  wb_value;

    assign mw_op     = op_of(mw_q.instr);
    assign mw_rd     = rd_of(mw_q.instr);
    assign mw_writes = mw_q.valid && writes_rd(mw_op) && (mw_rd != '0);
    assign wb_value  = (mw_op == OP_LW) ? mw_q.ld_data : mw_q.alu_res;

    assign address_dmem = xm_q.alu_res;
    assign wren         = xm_q.valid && (op_of(xm_q.instr) == OP_SW);

    // Store data from the instruction right ahead, covers lw then sw
    assign data = (mw_writes && (mw_rd == rd_of(xm_q.instr))) ? wb_value : xm_q.st_data;

    always_comb begin
        mw.valid   = xm_q.valid;
        mw.instr   = xm_q.instr;
        mw.alu_res = xm_q.alu_res;
        mw.ld_data = q_dmem;
    end

    assign ctrl_writeEnable = mw_writes;
    assign ctrl_writeReg    = mw_rd;
    assign data_writeReg    = wb_value;
    assign wb_data          = wb_value;

endmodule

// File: hw/execute_unit.sv
`timescale 1ns/1ns
`include "proc_params.svh"

module execute_unit import isa_pkg::*, pipe_pkg::*; (
    input  dx_t              dx,
    input  xm_t              xm_q,
    input  mw_t              mw_q,
    input  logic [`XLEN-1:0] wb_data,
    output xm_t              xm,
    output logic             redirect,
    output logic [`XLEN-1:0] redirect_pc
);

    opcode_t           dx_op;
    opcode_t           xm_op;
    logic [`REG_W-1:0] src_a;
    logic [`REG_W-1:0] src_b;
    logic [`REG_W-1:0] xm_rd;
    logic [`REG_W-1:0] mw_rd;
    logic              xm_fwd;
    logic              mw_fwd;
    logic [`XLEN-1:0]  a_val;
    logic [`XLEN-1:0]  b_val;
    logic [`XLEN-1:0]  imm;
    logic              use_imm;
    logic [`XLEN-1:0]  alu_b;
    alu_op_t           alu_op;
    logic [4:0]        shamt;
    logic [`XLEN-1:0]  alu_res;
    logic              bne_taken;
    logic              blt_taken;
    logic              is_jump;

    assign dx_op = op_of(dx.instr);
    assign xm_op = op_of(xm_q.instr);
    assign src_a = rs_of(dx.instr);
    assign src_b = reads_rd_as_b(dx_op) ? rd_of(dx.instr) : rt_of(dx.instr);
    assign xm_rd = rd_of(xm_q.instr);
    assign mw_rd = rd_of(mw_q.instr);

    // A lw in memory has no data yet, so only R and addi forward from XM
    assign xm_fwd = xm_q.valid && (xm_rd != '0) && ((xm_op == OP_R) || (xm_op == OP_ADDI));
    assign mw_fwd = mw_q.valid && (mw_rd != '0) && writes_rd(op_of(mw_q.instr));

    // Newest producer first
    always_comb begin
        if (xm_fwd && (xm_rd == src_a)) begin
            a_val = xm_q.alu_res;
        end else if (mw_fwd && (mw_rd == src_a)) begin
            a_val = wb_data;
        end else begin
            a_val = dx.op_a;
        end

        if (xm_fwd && (xm_rd == src_b)) begin
            b_val = xm_q.alu_res;
        end else if (mw_fwd && (mw_rd == src_b)) begin
            b_val = wb_data;
        end else begin
            b_val = dx.op_b;
        end
    end

    assign imm     = imm_of(dx.instr);
    assign use_imm = (dx_op == OP_ADDI) || (dx_op == OP_LW) || (dx_op == OP_SW);
    assign alu_b   = use_imm ? imm : b_val;
    assign alu_op  = use_imm ? ALU_ADD : alu_op_of(dx.instr);
    assign shamt   = shamt_of(dx.instr);

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_res = a_val + alu_b;
            ALU_SUB: alu_res = a_val - alu_b;
            ALU_AND: alu_res = a_val & alu_b;
            ALU_OR:  alu_res = a_val | alu_b;
            ALU_SLL: alu_res = a_val << shamt;
            ALU_SRA: alu_res = $signed(a_val) >>> shamt;
            default: alu_res = '0;
        endcase
    end

    // Branches compare rd (port B) against rs (port A)
    assign bne_taken = (dx_op == OP_BNE) && (b_val != a_val);
    assign blt_taken = (dx_op == OP_BLT) && ($signed(b_val) < $signed(a_val));
    assign is_jump   = (dx_op == OP_J);

    assign redirect    = dx.valid && (bne_taken || blt_taken || is_jump);
    assign redirect_pc = is_jump ? target_of(dx.instr) : dx.pc1 + imm;

    always_comb begin
        xm.valid   = dx.valid;
        xm.instr   = dx.instr;
        xm.alu_res = alu_res;
        xm.st_data = b_val;
    end

endmodule

// File: hw/decode_unit.sv
`timescale 1ns/1ns
`include "proc_params.svh"

module decode_unit import isa_pkg::*, pipe_pkg::*; (
    input  fd_t               fd,
    input  dx_t               dx_q,
    input  logic [`XLEN-1:0]  data_readRegA,
    input  logic [`XLEN-1:0]  data_readRegB,
    output logic [`REG_W-1:0] ctrl_readRegA,
    output logic [`REG_W-1:0] ctrl_readRegB,
    output dx_t               dx,
    output logic              stall
);

    opcode_t           fd_op;
    logic              uses_a;
    logic              uses_b;
    logic [`REG_W-1:0] load_rd;
    logic              load_in_dx;

    assign fd_op = op_of(fd.instr);

    // Stores and branches read rd on port B
    assign ctrl_readRegA = rs_of(fd.instr);
    assign ctrl_readRegB = reads_rd_as_b(fd_op) ? rd_of(fd.instr) : rt_of(fd.instr);

    // Source usage, sw left out since its data is bypassed in memory
    assign uses_a = (fd_op != OP_J);
    assign uses_b = (fd_op == OP_R) || (fd_op == OP_BNE) || (fd_op == OP_BLT);

    assign load_rd    = rd_of(dx_q.instr);
    assign load_in_dx = dx_q.valid && (op_of(dx_q.instr) == OP_LW) && (load_rd != '0);

    // Load data is not ready until the lw leaves memory
    assign stall = fd.valid && load_in_dx &&
                   ((uses_a && (ctrl_readRegA == load_rd)) ||
                    (uses_b && (ctrl_readRegB == load_rd)));

    always_comb begin
        dx.valid = fd.valid;
        dx.instr = fd.instr;
        dx.pc1   = fd.pc1;
        dx.op_a  = data_readRegA;
        dx.op_b  = data_readRegB;
    end

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ns
`include "proc_params.svh"

module fetch_unit import pipe_pkg::*; (
    input  logic               clock,
    input  logic               rst,
    input  logic               stall,
    input  logic               redirect,
    input  logic [`XLEN-1:0]   redirect_pc,
    input  logic [`XLEN-1:0]   q_imem,
    output logic [`IMEM_W-1:0] address_imem,
    output fd_t                fd
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_plus1;

    assign pc_plus1 = pc + `XLEN'd1;

    // Redirect wins over a stall
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc_plus1;
        end
    end

    assign address_imem = pc[`IMEM_W-1:0];

    always_comb begin
        fd.valid = 1'b1;
        fd.instr = q_imem;
        fd.pc1   = pc_plus1;
    end

endmodule

// File: hw/stage_latch.sv
`timescale 1ns/1ns

module stage_latch #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     rst,
    input  logic     en,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // An all-zero payload has valid low and acts as a bubble
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            q <= payload_t'('0);
        end else if (en) begin
            q <= d;
        end
    end

endmodule

// File: hw/pipe_pkg.sv
`include "proc_params.svh"

package pipe_pkg;

    // Fetch to decode
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  instr;
        logic [`XLEN-1:0]  pc1;
    } fd_t;

    // Decode to execute, operands as read from the register file
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  instr;
        logic [`XLEN-1:0]  pc1;
        logic [`XLEN-1:0]  op_a;
        logic [`XLEN-1:0]  op_b;
    } dx_t;

    // Execute to memory
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  instr;
        logic [`XLEN-1:0]  alu_res;
        logic [`XLEN-1:0]  st_data;
    } xm_t;

    // Memory to writeback
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  instr;
        logic [`XLEN-1:0]  alu_res;
        logic [`XLEN-1:0]  ld_data;
    } mw_t;

endpackage

// File: hw/isa_pkg.sv
`include "proc_params.svh"

package isa_pkg;

    typedef enum logic [4:0] {
        OP_R    = 5'b00000,
        OP_J    = 5'b00001,
        OP_BNE  = 5'b00010,
        OP_ADDI = 5'b00101,
        OP_BLT  = 5'b00110,
        OP_SW   = 5'b00111,
        OP_LW   = 5'b01000
    } opcode_t;

    // ALU op field of R-type words
    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_t;

    function automatic opcode_t op_of(input logic [`XLEN-1:0] instr);
        return opcode_t'(instr[31:27]);
    endfunction

    function automatic logic [`REG_W-1:0] rd_of(input logic [`XLEN-1:0] instr);
        return instr[26:22];
    endfunction

    function automatic logic [`REG_W-1:0] rs_of(input logic [`XLEN-1:0] instr);
        return instr[21:17];
    endfunction

    function automatic logic [`REG_W-1:0] rt_of(input logic [`XLEN-1:0] instr);
        return instr[16:12];
    endfunction

    function automatic logic [4:0] shamt_of(input logic [`XLEN-1:0] instr);
        return instr[11:7];
    endfunction

    function automatic alu_op_t alu_op_of(input logic [`XLEN-1:0] instr);
        return alu_op_t'(instr[6:2]);
    endfunction

    // Sign-extended 17-bit immediate
    function automatic logic [`XLEN-1:0] imm_of(input logic [`XLEN-1:0] instr);
        return {{(`XLEN-17){instr[16]}}, instr[16:0]};
    endfunction

    function automatic logic [`XLEN-1:0] target_of(input logic [`XLEN-1:0] instr);
        return {{(`XLEN-27){1'b0}}, instr[26:0]};
    endfunction

    // Second source register is rd rather than rt
    function automatic logic reads_rd_as_b(input opcode_t op);
        return (op == OP_SW) || (op == OP_BNE) || (op == OP_BLT);
    endfunction

    function automatic logic writes_rd(input opcode_t op);
        return (op == OP_R) || (op == OP_ADDI) || (op == OP_LW);
    endfunction

endpackage

// File: hw/proc_params.svh
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

// Data and instruction word width
`define XLEN 32

// Register file address width
`define REG_W 5

// Instruction memory word address width
`define IMEM_W 12

`endif
